//--- hdl/daq_tx_cfg.svh
`ifndef DAQ_TX_CFG_SVH
`define DAQ_TX_CFG_SVH

// Datapath widths
`define DAQ_WORD_W     16            // Symbol word, two octets per clock
`define DAQ_K_W        2             // One K flag per octet
`define DAQ_CRC_W      32
`define DAQ_ROM_AW     3             // Ordered set ROM address
`define DAQ_CNT_W      3             // Preamble and gap counters

// Frame timing
`define DAQ_PRE_WORDS  2             // Plain preamble words between SOP and SOF
`define DAQ_IFG_WORDS  6             // Minimum idle words after Carrier Extend

// Ethernet CRC-32, reflected form
`define DAQ_CRC_POLY   32'hEDB88320
`define DAQ_CRC_SEED   32'hFFFFFFFF

// 8b/10b octets
`define DAQ_K28_5      8'hBC         // Comma
`define DAQ_D16_2      8'h50
`define DAQ_K27_7      8'hFB         // /S/ start of packet
`define DAQ_K29_7      8'hFD         // /T/ end of packet
`define DAQ_K23_7      8'hF7         // /R/ carrier extend
`define DAQ_PRMBL      8'h55         // Preamble octet
`define DAQ_SFD        8'hD5         // Start of frame delimiter

// Ordered set words, low octet first, K flag of low octet in bit 0
`define DAQ_IDLE2      {`DAQ_D16_2, `DAQ_K28_5}
`define DAQ_IDLE2_K    2'b01
`define DAQ_SOP_PRE    {`DAQ_PRMBL, `DAQ_K27_7}
`define DAQ_SOP_PRE_K  2'b01
`define DAQ_PREAMBLE   {`DAQ_PRMBL, `DAQ_PRMBL}
`define DAQ_PREAMBLE_K 2'b00
`define DAQ_SOF_PRE    {`DAQ_SFD, `DAQ_PRMBL}
`define DAQ_SOF_PRE_K  2'b00
`define DAQ_EOP        {`DAQ_K23_7, `DAQ_K29_7}
`define DAQ_EOP_K      2'b11
`define DAQ_CEXT       {`DAQ_K23_7, `DAQ_K23_7}
`define DAQ_CEXT_K     2'b11

// Ordered set ROM map
`define DAQ_ADDR_IDLE  3'd0
`define DAQ_ADDR_SOP   3'd1
`define DAQ_ADDR_PRE   3'd2
`define DAQ_ADDR_SOF   3'd3
`define DAQ_ADDR_EOP   3'd5
`define DAQ_ADDR_CEXT  3'd6

`endif

//--- hdl/daq_tx_pkg.sv
`include "daq_tx_cfg.svh"

package daq_tx_pkg;

	typedef logic [`DAQ_WORD_W-1:0] daq_word_t;  // Symbol or user data word
	typedef logic [`DAQ_K_W-1:0]    charisk_t;   // K flags, bit 0 for the low octet
	typedef logic [`DAQ_CRC_W-1:0]  crc_t;
	typedef logic [`DAQ_ROM_AW-1:0] rom_addr_t;

	// Packet sequencer states
	typedef enum logic [3:0]
	{
		ST_IDLE,    // Idles, waiting for a request
		ST_GAP,     // Inter packet gap
		ST_SOP,
		ST_PRE,
		ST_SOF,     // Acknowledge goes out here
		ST_DATA,
		ST_CRC_LO,
		ST_CRC_HI,
		ST_EOP,
		ST_CEXT
	} frame_state_e;

	// Source of the outgoing word
	typedef enum logic [1:0]
	{
		SEL_ROM,
		SEL_DATA,
		SEL_CRC_LO,
		SEL_CRC_HI
	} word_sel_e;

endpackage

//--- hdl/frame_ordered_set_rom.sv
`timescale 1ns/1ps
`include "daq_tx_cfg.svh"

module frame_ordered_set_rom
(
	input  logic                  usr_clk_wordwise,
	input  daq_tx_pkg::rom_addr_t rom_addr_i,
	output daq_tx_pkg::daq_word_t set_word_o,   // Ordered set word, one cycle after address
	output daq_tx_pkg::charisk_t  set_k_o       // Matching K flags
);

// Word and K flags come from the same table so they always stay aligned
always_ff @(posedge usr_clk_wordwise)
begin
	case (rom_addr_i)
		`DAQ_ADDR_SOP:
		begin
			set_word_o <= `DAQ_SOP_PRE;     // /S/ plus first preamble octet
			set_k_o    <= `DAQ_SOP_PRE_K;
		end
		`DAQ_ADDR_PRE:
		begin
			set_word_o <= `DAQ_PREAMBLE;
			set_k_o    <= `DAQ_PREAMBLE_K;
		end
		`DAQ_ADDR_SOF:
		begin
			set_word_o <= `DAQ_SOF_PRE;     // Last preamble octet plus SFD
			set_k_o    <= `DAQ_SOF_PRE_K;
		end
		`DAQ_ADDR_EOP:
		begin
			set_word_o <= `DAQ_EOP;         // /T/ then /R/
			set_k_o    <= `DAQ_EOP_K;
		end
		`DAQ_ADDR_CEXT:
		begin
			set_word_o <= `DAQ_CEXT;
			set_k_o    <= `DAQ_CEXT_K;
		end
		default:                            // Idle address and unused slots
		begin
			set_word_o <= `DAQ_IDLE2;
			set_k_o    <= `DAQ_IDLE2_K;
		end
	endcase
end

endmodule

//--- hdl/frame_sequencer.sv
`timescale 1ns/1ps
`include "daq_tx_cfg.svh"

module frame_sequencer
(
	input  logic                  usr_clk_wordwise,
	input  logic                  arst,
	input  logic                  txd_vld_i,    // Packet request, later data valid
	output logic                  tx_ack_o,     // Data may start next cycle
	output daq_tx_pkg::rom_addr_t rom_addr_o,
	output logic                  crc_init_o,
	output logic                  crc_en_o,
	output daq_tx_pkg::word_sel_e word_sel_o
);

typedef logic [`DAQ_CNT_W-1:0] cnt_t;

daq_tx_pkg::frame_state_e state_q;     // Registered state
daq_tx_pkg::frame_state_e state_cur;   // What this slot actually carries
daq_tx_pkg::frame_state_e state_d;
cnt_t pre_cnt_q;
cnt_t gap_cnt_q;
logic pre_done;
logic gap_done;

assign pre_done = (pre_cnt_q == cnt_t'(`DAQ_PRE_WORDS - 1));
assign gap_done = (gap_cnt_q == cnt_t'(`DAQ_IFG_WORDS - 1));

////////////////////////////////////////////////////////////
// State machine
////////////////////////////////////////////////////////////

// First cycle without valid already is the low CRC slot, no hole in the stream
always_comb
begin
	state_cur = state_q;
	if (state_q == daq_tx_pkg::ST_DATA && !txd_vld_i)
		state_cur = daq_tx_pkg::ST_CRC_LO;
end

always_comb
begin
	state_d = state_cur;
	case (state_cur)
		daq_tx_pkg::ST_IDLE:   if (txd_vld_i) state_d = daq_tx_pkg::ST_SOP;
		daq_tx_pkg::ST_GAP:    if (gap_done) state_d = daq_tx_pkg::ST_IDLE;
		daq_tx_pkg::ST_SOP:    state_d = daq_tx_pkg::ST_PRE;
		daq_tx_pkg::ST_PRE:    if (pre_done) state_d = daq_tx_pkg::ST_SOF;
		daq_tx_pkg::ST_SOF:    state_d = daq_tx_pkg::ST_DATA;
		daq_tx_pkg::ST_DATA:   state_d = daq_tx_pkg::ST_DATA;    // Held by valid
		daq_tx_pkg::ST_CRC_LO: state_d = daq_tx_pkg::ST_CRC_HI;
		daq_tx_pkg::ST_CRC_HI: state_d = daq_tx_pkg::ST_EOP;
		daq_tx_pkg::ST_EOP:    state_d = daq_tx_pkg::ST_CEXT;
		daq_tx_pkg::ST_CEXT:   state_d = daq_tx_pkg::ST_GAP;
		default:               state_d = daq_tx_pkg::ST_GAP;
	endcase
end

always_ff @(posedge usr_clk_wordwise or posedge arst)
begin
	if (arst)
		state_q <= daq_tx_pkg::ST_GAP;   // Full gap before the first packet
	else
		state_q <= state_d;
end

// Preamble and gap run lengths
always_ff @(posedge usr_clk_wordwise or posedge arst)
begin
	if (arst)
	begin
		pre_cnt_q <= '0;
		gap_cnt_q <= '0;
	end
	else
	begin
		pre_cnt_q <= (state_cur == daq_tx_pkg::ST_PRE) ? pre_cnt_q + 1'b1 : '0;
		gap_cnt_q <= (state_cur == daq_tx_pkg::ST_GAP) ? gap_cnt_q + 1'b1 : '0;
	end
end

////////////////////////////////////////////////////////////
// Slot decode
////////////////////////////////////////////////////////////

assign tx_ack_o   = (state_q == daq_tx_pkg::ST_SOF);
assign crc_init_o = (state_cur == daq_tx_pkg::ST_SOP);   // Seed ahead of the data
assign crc_en_o   = (state_cur == daq_tx_pkg::ST_DATA);  // Only with valid high

always_comb
begin
	rom_addr_o = `DAQ_ADDR_IDLE;
	word_sel_o = daq_tx_pkg::SEL_ROM;
	case (state_cur)
		daq_tx_pkg::ST_SOP:    rom_addr_o = `DAQ_ADDR_SOP;
		daq_tx_pkg::ST_PRE:    rom_addr_o = `DAQ_ADDR_PRE;
		daq_tx_pkg::ST_SOF:    rom_addr_o = `DAQ_ADDR_SOF;
		daq_tx_pkg::ST_EOP:    rom_addr_o = `DAQ_ADDR_EOP;
		daq_tx_pkg::ST_CEXT:   rom_addr_o = `DAQ_ADDR_CEXT;
		daq_tx_pkg::ST_DATA:   word_sel_o = daq_tx_pkg::SEL_DATA;
		daq_tx_pkg::ST_CRC_LO: word_sel_o = daq_tx_pkg::SEL_CRC_LO;
		daq_tx_pkg::ST_CRC_HI: word_sel_o = daq_tx_pkg::SEL_CRC_HI;
		default:               rom_addr_o = `DAQ_ADDR_IDLE;  // Idle and gap
	endcase
end

// Source keeps its request up until the first data slot
a_vld_held: assert property (@(posedge usr_clk_wordwise) disable iff (arst)
	(state_q inside {daq_tx_pkg::ST_SOP, daq_tx_pkg::ST_PRE, daq_tx_pkg::ST_SOF})
	|-> txd_vld_i);

// Single acknowledge, the shortest packet tail keeps it low for four more cycles
a_ack_pulse: assert property (@(posedge usr_clk_wordwise) disable iff (arst)
	tx_ack_o |=> !tx_ack_o [*4]);

endmodule

//--- hdl/crc32_gen.sv
`timescale 1ns/1ps
`include "daq_tx_cfg.svh"

module crc32_gen
(
	input  logic                  usr_clk_wordwise,
	input  logic                  arst,
	input  logic                  init_i,     // Load the seed
	input  logic                  en_i,       // Fold in data_i
	input  daq_tx_pkg::daq_word_t data_i,
	output daq_tx_pkg::crc_t      crc_o       // Complemented, ready to send
);

daq_tx_pkg::crc_t crc_q;

// Bitwise LFSR step, low octet first and LSB first within each octet
function automatic daq_tx_pkg::crc_t crc_word
(
	input daq_tx_pkg::crc_t      crc_in,
	input daq_tx_pkg::daq_word_t d
);
	daq_tx_pkg::crc_t c;
	logic fb;
	c = crc_in;
	for (int i = 0; i < `DAQ_WORD_W; i++)
	begin
		fb = c[0] ^ d[i];
		c  = c >> 1;
		if (fb)
			c = c ^ `DAQ_CRC_POLY;
	end
	return c;
endfunction

always_ff @(posedge usr_clk_wordwise or posedge arst)
begin
	if (arst)
		crc_q <= `DAQ_CRC_SEED;
	else if (init_i)
		crc_q <= `DAQ_CRC_SEED;
	else if (en_i)
		crc_q <= crc_word(crc_q, data_i);   // Two octets per clock
end

assign crc_o = ~crc_q;   // Ethernet FCS is the inverted remainder

// Sequencer never seeds and accumulates in one slot
a_init_en: assert property (@(posedge usr_clk_wordwise) disable iff (arst)
	!(init_i && en_i));

endmodule

//--- hdl/tx_word_mux.sv
`timescale 1ns/1ps
`include "daq_tx_cfg.svh"

module tx_word_mux
(
	input  logic                  usr_clk_wordwise,
	input  logic                  arst,
	input  daq_tx_pkg::word_sel_e word_sel_i,
	input  daq_tx_pkg::daq_word_t txd_i,        // Source data, valid in DATA slots
	input  daq_tx_pkg::daq_word_t set_word_i,   // ROM word, already one cycle late
	input  daq_tx_pkg::charisk_t  set_k_i,
	input  daq_tx_pkg::crc_t      crc_i,
	output daq_tx_pkg::daq_word_t tx_data_o,    // To the serializer
	output daq_tx_pkg::charisk_t  tx_charisk_o
);

daq_tx_pkg::word_sel_e sel_q;   // Select lined up with ROM latency
daq_tx_pkg::daq_word_t data_q;  // Data lined up with ROM latency

////////////////////////////////////////////////////////////
// Alignment stage
////////////////////////////////////////////////////////////

always_ff @(posedge usr_clk_wordwise or posedge arst)
begin
	if (arst)
		sel_q <= daq_tx_pkg::SEL_ROM;
	else
		sel_q <= word_sel_i;
end

always_ff @(posedge usr_clk_wordwise)
begin
	data_q <= txd_i;
end

////////////////////////////////////////////////////////////
// Output register
////////////////////////////////////////////////////////////

always_ff @(posedge usr_clk_wordwise or posedge arst)
begin
	if (arst)
	begin
		tx_data_o    <= `DAQ_IDLE2;       // Line idles out of reset
		tx_charisk_o <= `DAQ_IDLE2_K;
	end
	else
	begin
		case (sel_q)
			daq_tx_pkg::SEL_DATA:   tx_data_o <= data_q;
			daq_tx_pkg::SEL_CRC_LO: tx_data_o <= crc_i[`DAQ_WORD_W-1:0];   // Low half first
			daq_tx_pkg::SEL_CRC_HI: tx_data_o <= crc_i[`DAQ_CRC_W-1:`DAQ_WORD_W];
			default:                tx_data_o <= set_word_i;
		endcase
		// Payload and FCS are plain data characters
		tx_charisk_o <= (sel_q == daq_tx_pkg::SEL_ROM) ? set_k_i : '0;
	end
end

endmodule

//--- hdl/daq_frame_tx.sv
`timescale 1ns/1ps

module daq_frame_tx
(
	input  logic                  usr_clk_wordwise,
	input  logic                  arst,
	input  daq_tx_pkg::daq_word_t txd_i,        // User data
	input  logic                  txd_vld_i,    // Request, then data valid
	output logic                  tx_ack_o,     // First data slot follows
	output daq_tx_pkg::daq_word_t tx_data_o,    // Symbol word to the line
	output daq_tx_pkg::charisk_t  tx_charisk_o
);

daq_tx_pkg::rom_addr_t rom_addr;
daq_tx_pkg::word_sel_e word_sel;
daq_tx_pkg::daq_word_t set_word;
daq_tx_pkg::charisk_t  set_k;
daq_tx_pkg::crc_t      crc;
logic                  crc_init;
logic                  crc_en;

// Sequencer paces the whole pipeline
frame_sequencer u_seq
(
	.usr_clk_wordwise (usr_clk_wordwise),
	.arst             (arst),
	.txd_vld_i        (txd_vld_i),
	.tx_ack_o         (tx_ack_o),
	.rom_addr_o       (rom_addr),
	.crc_init_o       (crc_init),
	.crc_en_o         (crc_en),
	.word_sel_o       (word_sel)
);

frame_ordered_set_rom u_rom
(
	.usr_clk_wordwise (usr_clk_wordwise),
	.rom_addr_i       (rom_addr),
	.set_word_o       (set_word),
	.set_k_o          (set_k)
);

crc32_gen u_crc
(
	.usr_clk_wordwise (usr_clk_wordwise),
	.arst             (arst),
	.init_i           (crc_init),
	.en_i             (crc_en),
	.data_i           (txd_i),           // Same cycle the word is accepted
	.crc_o            (crc)
);

tx_word_mux u_mux
(
	.usr_clk_wordwise (usr_clk_wordwise),
	.arst             (arst),
	.word_sel_i       (word_sel),
	.txd_i            (txd_i),
	.set_word_i       (set_word),
	.set_k_i          (set_k),
	.crc_i            (crc),
	.tx_data_o        (tx_data_o),
	.tx_charisk_o     (tx_charisk_o)
);

endmodule

//--- dv/daq_frame_tx_tb.sv
`timescale 1ns/1ps
`include "daq_tx_cfg.svh"

module daq_frame_tx_tb;

typedef logic [`DAQ_K_W+`DAQ_WORD_W-1:0] sym_t;    // {K flags, word}
typedef daq_tx_pkg::daq_word_t word_q_t[$];

localparam int ACK_TIMEOUT   = 100;   // Cycles from request to acknowledge
localparam int DRAIN_TIMEOUT = 200;   // Cycles for queued frames to leave the line

logic                  usr_clk_wordwise;
logic                  arst;
daq_tx_pkg::daq_word_t txd_i;
logic                  txd_vld_i;
logic                  tx_ack_o;
daq_tx_pkg::daq_word_t tx_data_o;
daq_tx_pkg::charisk_t  tx_charisk_o;

logic [31:0] rng_state = 32'h5fc03964;
string       test_name = "reset";
sym_t        exp_syms[$];          // Expected symbols of all pending frames
int          exp_lens[$];          // Words per pending frame
int          value_errors = 0;
int          protocol_errors = 0;
int          timeouts = 0;
int          packets_sent = 0;
int          acks_seen = 0;
int          words_left = 0;       // Words of the current frame still to compare
int          idle_run = 1000;      // Idle words since the last CEXT
logic        ack_prev = 1'b0;

daq_frame_tx UUT
(
	.usr_clk_wordwise (usr_clk_wordwise),
	.arst             (arst),
	.txd_i            (txd_i),
	.txd_vld_i        (txd_vld_i),
	.tx_ack_o         (tx_ack_o),
	.tx_data_o        (tx_data_o),
	.tx_charisk_o     (tx_charisk_o)
);

initial
begin
	usr_clk_wordwise = 1'b0;
	forever #5 usr_clk_wordwise = ~usr_clk_wordwise;   // 100 MHz word clock
end

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// xorshift32
function automatic logic [31:0] next_rand();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// Ethernet FCS one octet at a time with the low octet of each word first
function automatic logic [31:0] ref_crc32(input word_q_t data);
	logic [31:0] c;
	logic [7:0]  b;
	c = 32'hFFFFFFFF;
	foreach (data[i])
	begin
		for (int n = 0; n < 2; n++)
		begin
			b = (n == 0) ? data[i][7:0] : data[i][15:8];
			c = c ^ {24'h0, b};
			for (int j = 0; j < 8; j++)
				c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
		end
	end
	return ~c;
endfunction

function automatic void expected_frame(input word_q_t data);
	logic [31:0] fcs;
	fcs = ref_crc32(data);
	exp_syms.push_back({2'b01, `DAQ_SOP_PRE});
	repeat (`DAQ_PRE_WORDS)
		exp_syms.push_back({2'b00, `DAQ_PREAMBLE});
	exp_syms.push_back({2'b00, `DAQ_SOF_PRE});
	foreach (data[i])
		exp_syms.push_back({2'b00, data[i]});     // Payload goes out untouched
	exp_syms.push_back({2'b00, fcs[15:0]});
	exp_syms.push_back({2'b00, fcs[31:16]});
	exp_syms.push_back({2'b11, `DAQ_EOP});
	exp_syms.push_back({2'b11, `DAQ_CEXT});
	exp_lens.push_back(data.size() + `DAQ_PRE_WORDS + 6);
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (actual !== expected)
	begin
		value_errors++;
		$display("error in %s: expected %h, actual %h", name, expected, actual);
	end
endtask

////////////////////////////////////////////////////////////
// Stimulus
////////////////////////////////////////////////////////////

// Called just after a falling edge
task automatic send_packet(input int len);
	word_q_t     data;
	logic [31:0] r;
	int          wait_cnt;
	for (int i = 0; i < len; i++)
	begin
		r = next_rand();
		data.push_back(r[15:0]);
	end
	expected_frame(data);
	packets_sent++;
	txd_vld_i = 1'b1;                          // Request
	wait_cnt  = 0;
	while (!tx_ack_o && wait_cnt < ACK_TIMEOUT)
	begin
		@(negedge usr_clk_wordwise);
		wait_cnt++;
	end
	if (!tx_ack_o)
	begin
		timeouts++;
		$display("timeout: no acknowledge for the request in %s", test_name);
		txd_vld_i = 1'b0;
		return;
	end
	foreach (data[i])
	begin
		@(negedge usr_clk_wordwise);          // First slot is the cycle after SOF
		txd_i = data[i];
	end
	@(negedge usr_clk_wordwise);
	txd_vld_i = 1'b0;                          // Ends the data
	txd_i     = '0;
endtask

// Waits until every pending frame has left the line
task automatic drain_frames();
	int wait_cnt;
	wait_cnt = 0;
	while ((exp_lens.size() != 0 || words_left != 0) && wait_cnt < DRAIN_TIMEOUT)
	begin
		@(posedge usr_clk_wordwise);
		wait_cnt++;
	end
	if (exp_lens.size() != 0 || words_left != 0)
	begin
		timeouts++;
		$display("timeout: start of packet never seen or frame never ended in %s", test_name);
		exp_lens.delete();
		exp_syms.delete();
		words_left = 0;
	end
	@(negedge usr_clk_wordwise);
endtask

////////////////////////////////////////////////////////////
// Monitors
////////////////////////////////////////////////////////////

always @(negedge usr_clk_wordwise)
begin
	if (!arst)
	begin
		if (words_left != 0)
		begin
			check_value($sformatf("%s frame word", test_name), 32'(exp_syms.pop_front()),
				32'({tx_charisk_o, tx_data_o}));
			words_left--;
			if (words_left == 0)
				idle_run = 0;                  // CEXT just went out
		end
		else if ({tx_charisk_o, tx_data_o} == {2'b01, `DAQ_SOP_PRE})
		begin
			if (exp_lens.size() == 0)
			begin
				protocol_errors++;
				$display("start of packet without a pending packet in %s", test_name);
			end
			else
			begin
				if (idle_run < `DAQ_IFG_WORDS)
				begin
					protocol_errors++;
					$display("only %0d idle words before start of packet in %s",
						idle_run, test_name);
				end
				words_left = exp_lens.pop_front() - 1;
				exp_syms.delete(0);            // Start word itself found the frame
			end
		end
		else if ({tx_charisk_o, tx_data_o} == {2'b01, `DAQ_IDLE2})
			idle_run++;
		else
		begin
			protocol_errors++;
			$display("word %h with K flags %b outside a frame in %s",
				tx_data_o, tx_charisk_o, test_name);
		end
	end
end

// Acknowledge seen for the cycle that just ended
always @(posedge usr_clk_wordwise)
begin
	if (!arst)
	begin
		if (tx_ack_o)
		begin
			acks_seen++;
			if (!txd_vld_i)
			begin
				protocol_errors++;
				$display("acknowledge without a request in %s", test_name);
			end
			if (ack_prev)
			begin
				protocol_errors++;
				$display("acknowledge longer than one cycle in %s", test_name);
			end
		end
		ack_prev = tx_ack_o;
	end
end

////////////////////////////////////////////////////////////
// Test sequence
////////////////////////////////////////////////////////////

initial
begin
	logic [31:0] r;
	arst      = 1'b1;
	txd_i     = '0;
	txd_vld_i = 1'b0;
	repeat (8) @(negedge usr_clk_wordwise);
	arst = 1'b0;

	// Line idles with no acknowledge yet
	test_name = "reset_idle";
	repeat (12)
	begin
		@(negedge usr_clk_wordwise);
		check_value("reset_idle word", 32'({2'b01, `DAQ_IDLE2}), 32'({tx_charisk_o, tx_data_o}));
		check_value("reset_idle ack", 32'd0, 32'(tx_ack_o));
	end

	test_name = "single_random";
	r = next_rand();
	send_packet(int'(r % 40) + 1);
	drain_frames();

	test_name = "min_packet";
	send_packet(1);
	drain_frames();

	// Request comes back right after the one low cycle
	test_name = "back_to_back";
	for (int p = 0; p < 4; p++)
	begin
		r = next_rand();
		send_packet(int'(r % 40) + 1);
		@(negedge usr_clk_wordwise);
	end
	drain_frames();

	check_value("ack_count", 32'(packets_sent), 32'(acks_seen));
	$display("errors: value %0d, protocol %0d, timeout %0d",
		value_errors, protocol_errors, timeouts);
	if (value_errors + protocol_errors + timeouts == 0)
		$display("Everything OK");
	else
		$display("Something failed");
	$finish;
end

endmodule

//--- sim.f
+incdir+hdl
hdl/daq_tx_pkg.sv
hdl/frame_ordered_set_rom.sv
hdl/frame_sequencer.sv
hdl/crc32_gen.sv
hdl/tx_word_mux.sv
hdl/daq_frame_tx.sv
dv/daq_frame_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the frame transmitter testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module daq_frame_tx_tb -Mdir obj_dir -f sim.f \
	&& ./obj_dir/Vdaq_frame_tx_tb > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
